// ==== csr_pkg.sv ====
/* Host access types shared by the access pipeline and the register bank.
   Word addresses in a write command are limited to CSR_ADDR_W bits. */

package csr_pkg;

   // **************************************************
   // Widths
   // **************************************************

   // Widest word address a write command can carry
   localparam int unsigned CSR_ADDR_W = 8;

   // Register width and byte lanes
   localparam int unsigned CSR_DATA_W = 64;
   localparam int unsigned CSR_BE_W   = CSR_DATA_W / 8;

   // **************************************************
   // Host write encoding
   // **************************************************

   // Which part of the 64-bit word a host write touches
   typedef enum logic [1:0] {
      NONE    = 2'h0,
      UPPER32 = 2'h1,
      LOWER32 = 2'h2,
      FULL64  = 2'h3
   } csr_access_type_t;

   // The two 32-bit lanes of a register word
   typedef struct packed {
      logic [31:0] hi32;
      logic [31:0] lo32;
   } csr_half_t;

   // Write data seen as a whole word or as two lanes
   typedef union packed {
      logic [CSR_DATA_W-1:0] word;
      csr_half_t             half;
   } csr_wdata_u;

   // Pipelined write command as the register bank sees it
   typedef struct packed {
      logic                  valid;
      logic [CSR_ADDR_W-1:0] addr;   // zero-extended word address
      logic [CSR_BE_W-1:0]   be;     // one bit per byte lane
      csr_wdata_u            data;
   } csr_wr_cmd_t;

endpackage

// ==== prtcl_chkr_pkg.sv ====
/* Error vector layout and register map of the protocol checker.
   All error registers are six bits wide and read back zero-extended. */

package prtcl_chkr_pkg;

   // **************************************************
   // Error flags
   // **************************************************

   // One flag per protocol rule, driven by the checker every cycle
   typedef struct packed {
      logic max_read_req_size;       // read request above the size limit
      logic max_tag;                 // tag out of range
      logic unexp_mmio_rsp;          // response with no request outstanding
      logic mmio_timeout;            // request never answered
      logic mmio_data_overrun;       // response longer than requested
      logic mmio_insufficient_data;  // response shorter than requested
   } prtcl_chkr_err_t;

   // Flag count, used to slice the error bits out of a register word
   localparam int unsigned ERR_W = $bits(prtcl_chkr_err_t);

   // **************************************************
   // Register map (word addresses)
   // **************************************************

   // Sticky errors, write 1 to clear
   localparam int unsigned ERR_STATUS_ADDR = 0;

   // Snapshot of the first error after an all-clear, read only
   localparam int unsigned FIRST_ERR_ADDR  = 1;

   // Set bits block the matching incoming flags
   localparam int unsigned ERR_MASK_ADDR   = 2;

   // Free 64-bit read/write register for the host
   localparam int unsigned SCRATCH_ADDR    = 3;

   // Anything else reads zero and ignores writes

endpackage

// ==== csr_access_pipe.sv ====
/* csr_write is a one-cycle pulse; csr_read must be held until csr_readdata_valid
   and then dropped for at least one cycle. No back-pressure on either path. */

`timescale 1ns/1ps

module csr_access_pipe
   import csr_pkg::*;
#(
   parameter int unsigned ADDR_W = 6
) (
   input  logic                clk,
   input  logic                rst_n,

   // Host write strobe and payload
   input  logic                csr_write,
   input  logic [ADDR_W-1:0]   csr_waddr,
   input  csr_access_type_t    csr_write_type,
   input  csr_wdata_u          csr_wdata,

   // Host read level and address
   input  logic                csr_read,
   input  logic [ADDR_W-1:0]   csr_raddr,

   // Toward the register bank
   output csr_wr_cmd_t         wr_cmd,
   output logic                rd_req,
   output logic [ADDR_W-1:0]   rd_addr,

   // Back to the host
   output logic                csr_readdata_valid
);

   // **************************************************
   // Write pipeline
   // **************************************************

   // Stage 1 and 2 strobes
   logic                write_r1;
   logic                write_r2;

   // Stage 1 and 2 payload
   csr_access_type_t    type_r1;
   csr_access_type_t    type_r2;
   logic [ADDR_W-1:0]   waddr_r1;
   logic [ADDR_W-1:0]   waddr_r2;
   csr_wdata_u          wdata_r1;
   csr_wdata_u          wdata_r2;

   // Stage 3, the command handed to the bank
   logic                valid_r3;
   logic [CSR_BE_W-1:0] be_r3;
   logic [ADDR_W-1:0]   waddr_r3;
   csr_wdata_u          wdata_r3;

   // Strobe chain, the only write state under reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         write_r1 <= 1'b0;
         write_r2 <= 1'b0;
         valid_r3 <= 1'b0;
      end else begin
         write_r1 <= csr_write;
         write_r2 <= write_r1;
         valid_r3 <= write_r2;
      end
   end

   // Payload travels alongside the strobe
   always_ff @(posedge clk) begin
      type_r1  <= csr_write_type;
      waddr_r1 <= csr_waddr;
      wdata_r1 <= csr_wdata;

      type_r2  <= type_r1;
      waddr_r2 <= waddr_r1;
      wdata_r2 <= wdata_r1;

      waddr_r3 <= waddr_r2;

      // Last stage turns the write type into byte lanes
      case (type_r2)
         FULL64:  be_r3 <= 8'hFF;
         UPPER32: be_r3 <= 8'hF0;
         LOWER32: be_r3 <= 8'h0F;
         default: be_r3 <= 8'h00;
      endcase

      // Lanes outside the write are zeroed so the command carries clean data
      wdata_r3.half.hi32 <= (type_r2 inside {FULL64, UPPER32}) ? wdata_r2.half.hi32 : '0;
      wdata_r3.half.lo32 <= (type_r2 inside {FULL64, LOWER32}) ? wdata_r2.half.lo32 : '0;
   end

   // Address is zero-extended to the command field
   assign wr_cmd.valid = valid_r3;
   assign wr_cmd.addr  = CSR_ADDR_W'(waddr_r3);
   assign wr_cmd.be    = be_r3;
   assign wr_cmd.data  = wdata_r3;

   // **************************************************
   // Read path
   // **************************************************

   logic              read_r1;
   logic              read_r2;
   logic [ADDR_W-1:0] raddr_r1;
   logic              rd_done_r2;
   logic              rd_done_r3;

   // Rising edge of the held read level, one request per read
   assign rd_req  = read_r1 & ~read_r2;
   assign rd_addr = raddr_r1;

   // Address sampled with the level it belongs to
   always_ff @(posedge clk) begin
      raddr_r1 <= csr_raddr;
   end

   // Request edge, then a shift chain that ends in the valid pulse
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_r1            <= 1'b0;
         read_r2            <= 1'b0;
         rd_done_r2         <= 1'b0;
         rd_done_r3         <= 1'b0;
         csr_readdata_valid <= 1'b0;
      end else begin
         read_r1            <= csr_read;
         read_r2            <= read_r1;
         rd_done_r2         <= rd_req;
         rd_done_r3         <= rd_done_r2;
         csr_readdata_valid <= rd_done_r3;
      end
   end

endmodule

// ==== error_capture.sv ====
/* Masking applies to incoming flags only; bits already sticky stay until cleared.
   A flag that is set and cleared on the same edge stays set. */

`timescale 1ns/1ps

module error_capture
   import prtcl_chkr_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,

   // From the checker, sampled every cycle
   input  prtcl_chkr_err_t error_vector,

   // From the register bank
   input  prtcl_chkr_err_t err_mask,
   input  prtcl_chkr_err_t err_clear,    // one-cycle write-1-to-clear

   // Back to the register bank
   output prtcl_chkr_err_t err_sticky,
   output prtcl_chkr_err_t first_err,

   // Any error pending
   output logic            err_active
);

   // **************************************************
   // Next-state terms
   // **************************************************

   // Flags that get through the mask this cycle
   prtcl_chkr_err_t err_new;

   // Sticky vector after this edge
   prtcl_chkr_err_t sticky_next;

   // Idle means nothing is pending
   logic            sticky_clear;
   logic            new_seen;

   assign err_new      = error_vector & ~err_mask;

   // Clear first, then OR in new flags so a set wins
   assign sticky_next  = (err_sticky & ~err_clear) | err_new;

   assign sticky_clear = (err_sticky == '0);
   assign new_seen     = (err_new != '0);

   // **************************************************
   // State
   // **************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_sticky <= '0;
         first_err  <= '0;
         err_active <= 1'b0;
      end else begin
         err_sticky <= sticky_next;

         // Follows the sticky bits on the same edge
         err_active <= |sticky_next;

         // Snapshot only the first error after an all-clear
         // It then stays frozen until the host clears everything
         if (sticky_clear && new_seen) begin
            first_err <= err_new;
         end
      end
   end

endmodule

// ==== prtcl_chkr_regs.sv ====
/* FIRST_ERR is read only; writes to ERR_STATUS clear the enabled bits.
   Unmapped word addresses read zero and ignore writes. */

`timescale 1ns/1ps

module prtcl_chkr_regs
   import csr_pkg::*;
   import prtcl_chkr_pkg::*;
#(
   parameter int unsigned ADDR_W = 6
) (
   input  logic                  clk,
   input  logic                  rst_n,

   // From the access pipeline
   input  csr_wr_cmd_t           wr_cmd,
   input  logic                  rd_req,
   input  logic [ADDR_W-1:0]     rd_addr,

   // From error capture
   input  prtcl_chkr_err_t       err_sticky,
   input  prtcl_chkr_err_t       first_err,

   // To error capture
   output prtcl_chkr_err_t       err_mask,
   output prtcl_chkr_err_t       err_clear,

   // To the host
   output logic [CSR_DATA_W-1:0] csr_readdata
);

   // **************************************************
   // Write decode
   // **************************************************

   // Byte enables spread to one bit per data bit
   logic [CSR_DATA_W-1:0] wr_bits;
   logic [ADDR_W-1:0]     wr_addr;
   logic                  status_hit;
   logic                  mask_hit;
   logic                  scratch_hit;
   logic [CSR_DATA_W-1:0] scratch;

   always_comb begin
      for (int i = 0; i < CSR_BE_W; i++) begin
         wr_bits[i*8 +: 8] = {8{wr_cmd.be[i]}};
      end
   end

   assign wr_addr     = wr_cmd.addr[ADDR_W-1:0];
   assign status_hit  = wr_cmd.valid && (wr_addr == ADDR_W'(ERR_STATUS_ADDR));
   assign mask_hit    = wr_cmd.valid && (wr_addr == ADDR_W'(ERR_MASK_ADDR));
   assign scratch_hit = wr_cmd.valid && (wr_addr == ADDR_W'(SCRATCH_ADDR));

   // Clear pulse lasts exactly as long as the command
   assign err_clear = status_hit ?
                      prtcl_chkr_err_t'(wr_cmd.data.half.lo32[ERR_W-1:0] & wr_bits[ERR_W-1:0]) :
                      '0;

   // Mask and scratch keep every byte that is not enabled
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_mask <= '0;
         scratch  <= '0;
      end else begin
         if (mask_hit) begin
            err_mask <= prtcl_chkr_err_t'((err_mask & ~wr_bits[ERR_W-1:0]) |
                                          (wr_cmd.data.half.lo32[ERR_W-1:0] &
                                           wr_bits[ERR_W-1:0]));
         end
         if (scratch_hit) begin
            scratch <= (scratch & ~wr_bits) | (wr_cmd.data.word & wr_bits);
         end
      end
   end

   // **************************************************
   // Read mux
   // **************************************************

   // Data is captured once per request and held for the host
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         csr_readdata <= '0;
      end else if (rd_req) begin
         case (rd_addr)
            ADDR_W'(ERR_STATUS_ADDR): csr_readdata <= {{(CSR_DATA_W-ERR_W){1'b0}}, err_sticky};
            ADDR_W'(FIRST_ERR_ADDR):  csr_readdata <= {{(CSR_DATA_W-ERR_W){1'b0}}, first_err};
            ADDR_W'(ERR_MASK_ADDR):   csr_readdata <= {{(CSR_DATA_W-ERR_W){1'b0}}, err_mask};
            ADDR_W'(SCRATCH_ADDR):    csr_readdata <= scratch;
            default:                  csr_readdata <= '0;
         endcase
      end
   end

endmodule

// ==== prtcl_chkr_csr.sv ====
/* Single clock domain; the host drives plain strobes with no bus bridge.
   ADDR_W must be between 2 and 8 bits. */

`timescale 1ns/1ps

module prtcl_chkr_csr
   import csr_pkg::*;
   import prtcl_chkr_pkg::*;
#(
   parameter int unsigned ADDR_W = 6
) (
   input  logic                  clk,
   input  logic                  rst_n,

   // Host write side
   input  logic                  csr_write,
   input  logic [ADDR_W-1:0]     csr_waddr,
   input  csr_access_type_t      csr_write_type,
   input  csr_wdata_u            csr_wdata,

   // Host read side
   input  logic                  csr_read,
   input  logic [ADDR_W-1:0]     csr_raddr,
   output logic [CSR_DATA_W-1:0] csr_readdata,
   output logic                  csr_readdata_valid,

   // Checker side
   input  prtcl_chkr_err_t       error_vector,
   output logic                  err_active
);

   // Pipeline to bank
   csr_wr_cmd_t       wr_cmd;
   logic              rd_req;
   logic [ADDR_W-1:0] rd_addr;

   // Bank and error capture loop
   prtcl_chkr_err_t   err_mask;
   prtcl_chkr_err_t   err_clear;
   prtcl_chkr_err_t   err_sticky;
   prtcl_chkr_err_t   first_err;

   // **************************************************
   // Host access timing
   // **************************************************
   csr_access_pipe #(
      .ADDR_W (ADDR_W)
   ) access_pipe_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .csr_write          (csr_write),
      .csr_waddr          (csr_waddr),
      .csr_write_type     (csr_write_type),
      .csr_wdata          (csr_wdata),
      .csr_read           (csr_read),
      .csr_raddr          (csr_raddr),
      .wr_cmd             (wr_cmd),
      .rd_req             (rd_req),
      .rd_addr            (rd_addr),
      .csr_readdata_valid (csr_readdata_valid)
   );

   // Sticky flags and first-error snapshot
   error_capture error_capture_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .error_vector (error_vector),
      .err_mask     (err_mask),
      .err_clear    (err_clear),
      .err_sticky   (err_sticky),
      .first_err    (first_err),
      .err_active   (err_active)
   );

   // Register map and read data
   prtcl_chkr_regs #(
      .ADDR_W (ADDR_W)
   ) regs_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_cmd       (wr_cmd),
      .rd_req       (rd_req),
      .rd_addr      (rd_addr),
      .err_sticky   (err_sticky),
      .first_err    (first_err),
      .err_mask     (err_mask),
      .err_clear    (err_clear),
      .csr_readdata (csr_readdata)
   );

endmodule

// ==== tb_prtcl_chkr_csr.sv ====
/* Step-table testbench with a register model. Write settling and read latency
   follow the fixed pipeline depths, and every read wait is bounded. */

`timescale 1ns/1ps

module tb_prtcl_chkr_csr
   import csr_pkg::*;
   import prtcl_chkr_pkg::*;
();

   // **************************************************
   // Setup
   // **************************************************

   localparam int unsigned ADDR_W     = 6;
   localparam int          CLK_PERIOD = 10;
   localparam int          RST_CYCLES = 10;
   localparam int          WR_SETTLE  = 5;   // idle cycles until a write has landed
   localparam int          RD_LATENCY = 4;   // csr_read rise to csr_readdata_valid
   localparam int          RD_TIMEOUT = 20;
   localparam int          RD_HOLD    = 2;   // extra cycles csr_read stays high

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_ERR, OP_IDLE} op_t;

   // One row of the stimulus table
   typedef struct packed {
      op_t               op;
      logic [ADDR_W-1:0] addr;
      csr_access_type_t  wtype;
      logic              rnd;        // replace data with random words
      logic              chain;      // next write follows on the very next cycle
      logic [63:0]       data;
      prtcl_chkr_err_t   ev;
      logic              use_model;  // expected read value comes from the model
      logic [63:0]       exp;
   } step_t;

   step_t steps[$];

   logic              clk = 1'b0;
   logic              rst_n;
   logic              csr_write;
   logic [ADDR_W-1:0] csr_waddr;
   csr_access_type_t  csr_write_type;
   csr_wdata_u        csr_wdata;
   logic              csr_read;
   logic [ADDR_W-1:0] csr_raddr;
   logic [63:0]       csr_readdata;
   logic              csr_readdata_valid;
   prtcl_chkr_err_t   error_vector;
   logic              err_active;

   // Register model
   logic [63:0]       m_scratch;
   prtcl_chkr_err_t   m_mask;
   prtcl_chkr_err_t   m_sticky;
   prtcl_chkr_err_t   m_first;

   int                checks;
   int                value_errs;
   int                proto_errs;
   int                timeout_errs;
   integer            seed = 49;

   always #(CLK_PERIOD / 2) clk = ~clk;

   prtcl_chkr_csr #(
      .ADDR_W (ADDR_W)
   ) dut_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .csr_write          (csr_write),
      .csr_waddr          (csr_waddr),
      .csr_write_type     (csr_write_type),
      .csr_wdata          (csr_wdata),
      .csr_read           (csr_read),
      .csr_raddr          (csr_raddr),
      .csr_readdata       (csr_readdata),
      .csr_readdata_valid (csr_readdata_valid),
      .error_vector       (error_vector),
      .err_active         (err_active)
   );

   // **************************************************
   // Table building
   // **************************************************

   function automatic void push_write(input logic [ADDR_W-1:0] addr,
                                      input csr_access_type_t wt, input logic [63:0] data,
                                      input logic rnd, input logic chain);
      step_t s;
      s       = '0;
      s.op    = OP_WR;
      s.addr  = addr;
      s.wtype = wt;
      s.data  = data;
      s.rnd   = rnd;
      s.chain = chain;
      steps.push_back(s);
   endfunction

   function automatic void push_read(input logic [ADDR_W-1:0] addr, input logic use_model,
                                     input logic [63:0] exp);
      step_t s;
      s           = '0;
      s.op        = OP_RD;
      s.addr      = addr;
      s.use_model = use_model;
      s.exp       = exp;
      steps.push_back(s);
   endfunction

   function automatic void push_error(input prtcl_chkr_err_t ev);
      step_t s;
      s    = '0;
      s.op = OP_ERR;
      s.ev = ev;
      steps.push_back(s);
   endfunction

   function automatic void build_steps();
      step_t s;
      // Everything zero out of reset, unmapped too
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h0);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b0, 64'h0);
      push_read(ADDR_W'(ERR_MASK_ADDR), 1'b0, 64'h0);
      push_read(ADDR_W'(SCRATCH_ADDR), 1'b0, 64'h0);
      push_read(6'h3F, 1'b0, 64'h0);
      // Scratch lanes, NONE must leave the word alone
      push_write(ADDR_W'(SCRATCH_ADDR), FULL64, 64'h0, 1'b1, 1'b0);
      push_read(ADDR_W'(SCRATCH_ADDR), 1'b1, 64'h0);
      push_write(ADDR_W'(SCRATCH_ADDR), UPPER32, 64'h0, 1'b1, 1'b0);
      push_read(ADDR_W'(SCRATCH_ADDR), 1'b1, 64'h0);
      push_write(ADDR_W'(SCRATCH_ADDR), LOWER32, 64'h0, 1'b1, 1'b0);
      push_read(ADDR_W'(SCRATCH_ADDR), 1'b1, 64'h0);
      push_write(ADDR_W'(SCRATCH_ADDR), NONE, 64'h0, 1'b1, 1'b0);
      push_read(ADDR_W'(SCRATCH_ADDR), 1'b1, 64'h0);
      // Sticky flags, first error frozen
      push_error(6'b000101);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h05);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b0, 64'h05);
      push_error(6'b100000);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h25);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b0, 64'h05);
      // Mask blocks mmio_data_overrun
      push_write(ADDR_W'(ERR_MASK_ADDR), LOWER32, 64'hFFFF_FFFF_0000_0002, 1'b0, 1'b0);
      push_read(ADDR_W'(ERR_MASK_ADDR), 1'b0, 64'h02);
      push_error(6'b000010);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h25);
      // Partial clear, then a clear on the wrong lane, then a full clear
      push_write(ADDR_W'(ERR_STATUS_ADDR), FULL64, 64'h04, 1'b0, 1'b0);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h21);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b0, 64'h05);
      push_write(ADDR_W'(ERR_STATUS_ADDR), UPPER32, 64'h0000_003F_0000_003F, 1'b0, 1'b0);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h21);
      push_write(ADDR_W'(ERR_STATUS_ADDR), LOWER32, 64'h3F, 1'b0, 1'b0);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h0);
      // Next error after the all-clear reloads the snapshot
      push_error(6'b011010);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b0, 64'h18);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b0, 64'h18);
      // Back-to-back writes to four different addresses
      push_write(ADDR_W'(ERR_MASK_ADDR), FULL64, 64'h0, 1'b0, 1'b1);
      push_write(ADDR_W'(SCRATCH_ADDR), FULL64, 64'h0, 1'b1, 1'b1);
      push_write(ADDR_W'(ERR_STATUS_ADDR), FULL64, 64'h3F, 1'b0, 1'b1);
      push_write(6'h21, FULL64, 64'h0, 1'b1, 1'b0);
      push_read(ADDR_W'(ERR_MASK_ADDR), 1'b1, 64'h0);
      push_read(ADDR_W'(SCRATCH_ADDR), 1'b1, 64'h0);
      push_read(ADDR_W'(ERR_STATUS_ADDR), 1'b1, 64'h0);
      push_read(6'h21, 1'b0, 64'h0);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b1, 64'h0);
      push_error(6'b000010);
      push_read(ADDR_W'(FIRST_ERR_ADDR), 1'b1, 64'h0);
      s    = '0;
      s.op = OP_IDLE;
      steps.push_back(s);
   endfunction

   // **************************************************
   // Register model
   // **************************************************

   function automatic logic [63:0] model_read(input logic [ADDR_W-1:0] addr);
      logic [63:0] zext;
      zext = '0;
      if (addr == ADDR_W'(ERR_STATUS_ADDR)) begin
         zext[ERR_W-1:0] = m_sticky;
      end else if (addr == ADDR_W'(FIRST_ERR_ADDR)) begin
         zext[ERR_W-1:0] = m_first;
      end else if (addr == ADDR_W'(ERR_MASK_ADDR)) begin
         zext[ERR_W-1:0] = m_mask;
      end else if (addr == ADDR_W'(SCRATCH_ADDR)) begin
         zext = m_scratch;
      end
      return zext;
   endfunction

   function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                       input csr_access_type_t wt, input logic [63:0] d);
      logic hi_en;
      logic lo_en;
      hi_en = (wt == FULL64) || (wt == UPPER32);
      lo_en = (wt == FULL64) || (wt == LOWER32);
      // Error bits all sit in the low lane
      if (addr == ADDR_W'(ERR_STATUS_ADDR) && lo_en) begin
         m_sticky = m_sticky & ~d[ERR_W-1:0];
      end else if (addr == ADDR_W'(ERR_MASK_ADDR) && lo_en) begin
         m_mask = d[ERR_W-1:0];
      end else if (addr == ADDR_W'(SCRATCH_ADDR)) begin
         if (hi_en) begin
            m_scratch[63:32] = d[63:32];
         end
         if (lo_en) begin
            m_scratch[31:0] = d[31:0];
         end
      end
   endfunction

   function automatic void model_inject(input prtcl_chkr_err_t ev);
      prtcl_chkr_err_t new_bits;
      new_bits = ev & ~m_mask;
      // Snapshot only when nothing was pending
      if (m_sticky == '0 && new_bits != '0) begin
         m_first = new_bits;
      end
      m_sticky = m_sticky | new_bits;
   endfunction

   // **************************************************
   // Bus operations
   // **************************************************

   task automatic check_active();
      @(negedge clk);
      checks++;
      assert (err_active === (|m_sticky)) else begin
         $display("[ERROR] %0t err_active: expected %b, got %b", $time, |m_sticky, err_active);
         value_errs++;
      end
   endtask

   task automatic do_write(input step_t s);
      @(posedge clk);
      csr_write      <= 1'b1;
      csr_waddr      <= s.addr;
      csr_write_type <= s.wtype;
      csr_wdata      <= s.data;
      model_write(s.addr, s.wtype, s.data);
      if (!s.chain) begin
         @(posedge clk);
         csr_write <= 1'b0;
         repeat (WR_SETTLE) @(posedge clk);
      end
   endtask

   task automatic do_error(input prtcl_chkr_err_t ev);
      @(posedge clk);
      error_vector <= ev;
      @(posedge clk);
      error_vector <= '0;
      model_inject(ev);
   endtask

   task automatic do_read(input logic [ADDR_W-1:0] addr, input logic [63:0] exp);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      @(posedge clk);
      csr_read  <= 1'b1;
      csr_raddr <= addr;
      while (!seen && cycles < RD_TIMEOUT) begin
         @(negedge clk);
         if (csr_readdata_valid === 1'b1) begin
            seen = 1'b1;
         end else begin
            cycles++;
         end
      end
      checks++;
      assert (seen) else begin
         $display("Read of address 0x%0h timed out waiting for csr_readdata_valid", addr);
         timeout_errs++;
      end
      if (seen) begin
         assert (cycles == RD_LATENCY) else begin
            $display("Read of address 0x%0h took %0d cycles instead of %0d",
                     addr, cycles, RD_LATENCY);
            proto_errs++;
         end
         assert (csr_readdata === exp) else begin
            $display("[ERROR] %0t csr_readdata: expected 0x%h, got 0x%h",
                     $time, exp, csr_readdata);
            value_errs++;
         end
         // Level still held, a second pulse would be a repeated read
         repeat (RD_HOLD) begin
            @(negedge clk);
            assert (csr_readdata_valid === 1'b0) else begin
               $display("Read of address 0x%0h gave a second valid pulse", addr);
               proto_errs++;
            end
         end
      end
      @(posedge clk);
      csr_read <= 1'b0;
   endtask

   // **************************************************
   // Main sequence
   // **************************************************

   initial begin
      step_t       s;
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      rst_n          = 1'b0;
      csr_write      = 1'b0;
      csr_waddr      = '0;
      csr_write_type = NONE;
      csr_wdata      = '0;
      csr_read       = 1'b0;
      csr_raddr      = '0;
      error_vector   = '0;
      m_scratch      = '0;
      m_mask         = '0;
      m_sticky       = '0;
      m_first        = '0;
      checks         = 0;
      value_errs     = 0;
      proto_errs     = 0;
      timeout_errs   = 0;
      build_steps();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      check_active();
      foreach (steps[i]) begin
         s = steps[i];
         if (s.rnd) begin
            r_hi   = $random(seed);
            r_lo   = $random(seed);
            s.data = {r_hi, r_lo};
         end
         case (s.op)
            OP_WR:   do_write(s);
            OP_RD:   do_read(s.addr, s.use_model ? model_read(s.addr) : s.exp);
            OP_ERR:  do_error(s.ev);
            default: repeat (2) @(posedge clk);
         endcase
         // A chained write has not landed yet
         if (!(s.op == OP_WR && s.chain)) begin
            check_active();
         end
      end
      $display("Checks: %0d, value errors: %0d, protocol errors: %0d, timeouts: %0d",
               checks, value_errs, proto_errs, timeout_errs);
      if (value_errs + proto_errs + timeout_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== prtcl_chkr_csr.f ====
csr_pkg.sv
prtcl_chkr_pkg.sv
csr_access_pipe.sv
error_capture.sv
prtcl_chkr_regs.sv
prtcl_chkr_csr.sv
tb_prtcl_chkr_csr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CSR testbench with Verilator, runs it and judges the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   -f prtcl_chkr_csr.f \
   --top-module tb_prtcl_chkr_csr \
   -Mdir obj_dir

status=0
./obj_dir/Vtb_prtcl_chkr_csr > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG" || [ "$status" -ne 0 ]; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
